// File: hdl/sifhPkg.sv
`default_nettype none

package sifhPkg;

    // histogram geometry
    localparam int numBins      = 16;
    localparam int binAddrWidth = 4;
    localparam int countWidth   = 8;

    // bin index, 0 .. numBins-1
    typedef logic [binAddrWidth-1:0] binAddrT;
    // count of one bin, saturating
    typedef logic [countWidth-1:0] binCountT;
    // bit 0 -> CH, bit 1 -> FH
    typedef logic [1:0] histSelT;

    // saturation ceiling of a bin counter
    localparam binCountT countMax = '1;
    // last bin index, also upper clamp of the threshold window
    localparam binAddrT lastBin = binAddrT'(numBins - 1);
    // half width after reset
    localparam binAddrT cfgResetHalfWidth = binAddrT'(2);

    typedef struct packed {
        binAddrT halfWidth;
        histSelT histEnable;
    } sifhCfgT;

    // one readout beat, both histograms side by side
    typedef struct packed {
        logic     valid;
        logic     last;
        binAddrT  addr;
        binCountT chCount;
        binCountT fhCount;
    } binSampleT;

    typedef struct packed {
        logic    valid;
        binAddrT peakCH;
        binAddrT peakFH;
    } peakT;

    typedef struct packed {
        binAddrT thMinus;
        binAddrT thPositive;
        binAddrT delta;
    } thresholdT;

endpackage

`default_nettype wire

// File: hdl/thresholdConfig.sv
`timescale 1ns/1ps
`default_nettype none

module thresholdConfig (
    input  wire logic             clk,
    input  wire logic             arstN,
    input  wire logic             cfgWrite,
    input  wire sifhPkg::sifhCfgT cfgData,
    input  wire logic             busy,
    output sifhPkg::sifhCfgT      cfg
);

    // config register
    // frozen while the builder reads out, so a result always
    // sees the half width that was set when readout started
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cfg.halfWidth  <= sifhPkg::cfgResetHalfWidth;
            // both histograms enabled out of reset
            cfg.histEnable <= '1;
        end else if (cfgWrite && !busy) begin
            cfg <= cfgData;
        end
    end

endmodule

`default_nettype wire

// File: hdl/hisBuilderReg.sv
`timescale 1ns/1ps
`default_nettype none

module hisBuilderReg (
    input  wire logic              clk,
    input  wire logic              arstN,
    input  wire sifhPkg::histSelT  wrEn,
    input  wire sifhPkg::binAddrT  addr,
    input  wire logic              acqFinish,
    input  wire sifhPkg::sifhCfgT  cfg,
    output logic                   busy,
    output sifhPkg::binSampleT     sample
);

    typedef enum logic [1:0] {
        stIdle,
        stReadout,
        stDrain
    } stateT;

    stateT state;
    // read pointer, walks bins 0 .. numBins-1
    sifhPkg::binAddrT rdPtr;

    // index 0 -> CH, index 1 -> FH
    sifhPkg::binCountT hist [2][sifhPkg::numBins];

    // readout beat registers
    logic              beatValid;
    logic              beatLast;
    sifhPkg::binAddrT  beatAddr;
    sifhPkg::binCountT beatCh;
    sifhPkg::binCountT beatFh;

    // busy covers readout plus the one drain cycle
    assign busy = (state != stIdle);

    // state machine and both count arrays
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stIdle;
            rdPtr <= '0;
            for (int h = 0; h < 2; h++) begin
                for (int b = 0; b < sifhPkg::numBins; b++) begin
                    hist[h][b] <= '0;
                end
            end
        end else begin
            case (state)
                stIdle: begin
                    // counting, only when enabled and below the ceiling
                    for (int h = 0; h < 2; h++) begin
                        if (wrEn[h] && cfg.histEnable[h] &&
                            hist[h][addr] != sifhPkg::countMax) begin
                            hist[h][addr] <= hist[h][addr] + 1'b1;
                        end
                    end
                    if (acqFinish) begin
                        state <= stReadout;
                        rdPtr <= '0;
                    end
                end
                stReadout: begin
                    // clear-on-read
                    for (int h = 0; h < 2; h++) begin
                        hist[h][rdPtr] <= '0;
                    end
                    rdPtr <= rdPtr + 1'b1;
                    if (rdPtr == sifhPkg::lastBin) begin
                        state <= stDrain;
                    end
                end
                stDrain: begin
                    state <= stIdle;
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // beat strobes
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            beatValid <= 1'b0;
            beatLast  <= 1'b0;
        end else begin
            beatValid <= (state == stReadout);
            beatLast  <= (state == stReadout) && (rdPtr == sifhPkg::lastBin);
        end
    end

    // beat payload, sampled before the bin is cleared
    always_ff @(posedge clk) begin
        beatAddr <= rdPtr;
        beatCh   <= hist[0][rdPtr];
        beatFh   <= hist[1][rdPtr];
    end

    assign sample = '{
        valid:   beatValid,
        last:    beatLast,
        addr:    beatAddr,
        chCount: beatCh,
        fhCount: beatFh
    };

endmodule

`default_nettype wire

// File: hdl/peakDetecter.sv
`timescale 1ns/1ps
`default_nettype none

module peakDetecter (
    input  wire logic               clk,
    input  wire logic               arstN,
    input  wire sifhPkg::binSampleT sample,
    output sifhPkg::peakT           peak
);

    // per histogram, 0 -> CH, 1 -> FH
    sifhPkg::binCountT beatCount [2];
    sifhPkg::binCountT maxCount  [2];
    sifhPkg::binAddrT  maxBin    [2];
    logic              takeNew   [2];
    sifhPkg::binAddrT  nextBin   [2];

    logic              peakValid;
    sifhPkg::binAddrT  peakBin   [2];

    always_comb begin
        beatCount[0] = sample.chCount;
        beatCount[1] = sample.fhCount;
        for (int i = 0; i < 2; i++) begin
            // bin 0 restarts the search
            // strict compare keeps the lowest bin on a tie
            takeNew[i] = (sample.addr == '0) || (beatCount[i] > maxCount[i]);
            nextBin[i] = takeNew[i] ? sample.addr : maxBin[i];
        end
    end

    // running maxima
    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (sample.valid && takeNew[i]) begin
                maxCount[i] <= beatCount[i];
                maxBin[i]   <= sample.addr;
            end
        end
    end

    // latch result on the last beat
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            peakValid  <= 1'b0;
            peakBin[0] <= '0;
            peakBin[1] <= '0;
        end else begin
            peakValid <= sample.valid && sample.last;
            if (sample.valid && sample.last) begin
                peakBin[0] <= nextBin[0];
                peakBin[1] <= nextBin[1];
            end
        end
    end

    assign peak = '{valid: peakValid, peakCH: peakBin[0], peakFH: peakBin[1]};

endmodule

`default_nettype wire

// File: hdl/algebraicBlock.sv
`timescale 1ns/1ps
`default_nettype none

module algebraicBlock (
    input  wire logic             clk,
    input  wire logic             arstN,
    input  wire sifhPkg::peakT    peak,
    input  wire sifhPkg::sifhCfgT cfg,
    output sifhPkg::thresholdT    threshold,
    output logic                  resultValid
);

    // one spare bit to catch overflow past the last bin
    logic [sifhPkg::binAddrWidth:0] upperSum;
    sifhPkg::binAddrT               lowerTh;
    sifhPkg::binAddrT               upperTh;

    always_comb begin
        // lower edge, floor at bin 0
        if (peak.peakCH >= cfg.halfWidth) begin
            lowerTh = peak.peakCH - cfg.halfWidth;
        end else begin
            lowerTh = '0;
        end
        // upper edge, ceiling at the last bin
        upperSum = {1'b0, peak.peakCH} + {1'b0, cfg.halfWidth};
        if (upperSum > {1'b0, sifhPkg::lastBin}) begin
            upperTh = sifhPkg::lastBin;
        end else begin
            upperTh = upperSum[sifhPkg::binAddrWidth-1:0];
        end
    end

    // window values, updated once per result
    always_ff @(posedge clk) begin
        if (peak.valid) begin
            threshold.thMinus    <= lowerTh;
            threshold.thPositive <= upperTh;
            // never negative since upper >= lower
            threshold.delta      <= upperTh - lowerTh;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= peak.valid;
        end
    end

endmodule

`default_nettype wire

// File: hdl/sifhTop.sv
`timescale 1ns/1ps
`default_nettype none

module sifhTop (
    input  wire logic             clk,
    input  wire logic             arstN,
    input  wire sifhPkg::histSelT wrEn,
    input  wire sifhPkg::binAddrT addr,
    input  wire logic             acqFinish,
    input  wire logic             cfgWrite,
    input  wire sifhPkg::sifhCfgT cfgData,
    output logic                  busy,
    output sifhPkg::peakT         peakOut,
    output sifhPkg::thresholdT    threshold,
    output logic                  resultValid
);

    // live configuration
    sifhPkg::sifhCfgT   cfg;
    // readout stream, builder to peak search
    sifhPkg::binSampleT sample;

    // config, locked while busy
    thresholdConfig thresholdConfigU0 (
        .clk      (clk),
        .arstN    (arstN),
        .cfgWrite (cfgWrite),
        .cfgData  (cfgData),
        .busy     (busy),
        .cfg      (cfg)
    );

    // CH and FH arrays plus readout sequencer
    hisBuilderReg hisBuilderU0 (
        .clk       (clk),
        .arstN     (arstN),
        .wrEn      (wrEn),
        .addr      (addr),
        .acqFinish (acqFinish),
        .cfg       (cfg),
        .busy      (busy),
        .sample    (sample)
    );

    // peak bins, also exported
    peakDetecter peakDetecterU0 (
        .clk    (clk),
        .arstN  (arstN),
        .sample (sample),
        .peak   (peakOut)
    );

    // threshold window around the CH peak
    algebraicBlock algebraicBlockU0 (
        .clk         (clk),
        .arstN       (arstN),
        .peak        (peakOut),
        .cfg         (cfg),
        .threshold   (threshold),
        .resultValid (resultValid)
    );

endmodule

`default_nettype wire

// File: verification/sifhClockGen.sv
`timescale 1ns/1ps
`default_nettype none

module sifhClockGen (
    output logic clk,
    output logic arstN
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // reset held for 5 rising edges, released between edges
    initial begin
        arstN = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
    end

endmodule

`default_nettype wire

// File: verification/sifhChecker.sv
`timescale 1ns/1ps
`default_nettype none

module sifhChecker (
    input  wire logic               clk,
    input  wire logic               arstN,
    input  wire logic [3:0]         testId,
    input  wire sifhPkg::histSelT   wrEn,
    input  wire sifhPkg::binAddrT   addr,
    input  wire logic               acqFinish,
    input  wire logic               cfgWrite,
    input  wire sifhPkg::sifhCfgT   cfgData,
    input  wire logic               busy,
    input  wire sifhPkg::peakT      peakOut,
    input  wire sifhPkg::thresholdT threshold,
    input  wire logic               resultValid,
    output int                      mismatchCount,
    output int                      pulseErrors
);

    // saturation ceiling of a bin
    localparam int countCeil = (1 << sifhPkg::countWidth) - 1;

    // reference histograms, 0 -> CH, 1 -> FH
    int                 modelHist [2][sifhPkg::numBins];
    sifhPkg::sifhCfgT   modelCfg;
    // busy cycles still to come
    int                 busyLeft;
    int                 cycle;
    // pending results, oldest first
    int                 dueQ [$];
    sifhPkg::peakT      expPeakQ [$];
    sifhPkg::thresholdT expThQ [$];

    function automatic string testLabel(input logic [3:0] id);
        case (id)
            4'd1:    return "randomCount";
            4'd2:    return "saturation";
            4'd3:    return "thresholdClamp";
            4'd4:    return "writeEnable";
            4'd5:    return "readoutLockout";
            default: return "startup";
        endcase
    endfunction

    task automatic checkValue(input string what, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        if (actVal !== expVal) begin
            $display("MISMATCH %s %s expected %0d actual %0d",
                     testLabel(testId), what, expVal, actVal);
            mismatchCount++;
        end
    endtask

    initial begin
        mismatchCount = 0;
        pulseErrors   = 0;
        cycle         = 0;
    end

    always @(posedge clk or negedge arstN) begin : modelStep
        logic expValid;
        logic expPeakValid;
        int   best;
        int   bin [2];
        int   pk;
        int   hw;
        int   lower;
        int   upper;
        if (!arstN) begin
            for (int h = 0; h < 2; h++) begin
                for (int b = 0; b < sifhPkg::numBins; b++) begin
                    modelHist[h][b] = 0;
                end
            end
            modelCfg = '{halfWidth: sifhPkg::cfgResetHalfWidth, histEnable: 2'b11};
            busyLeft = 0;
            dueQ.delete();
            expPeakQ.delete();
            expThQ.delete();
        end else begin
            cycle++;
            // DUT outputs here still hold the previous cycle's values
            checkValue("busy", busyLeft != 0, busy);
            expValid = (dueQ.size() > 0) && (dueQ[0] == cycle);
            // peak pulse comes one cycle ahead of the result
            expPeakValid = (dueQ.size() > 0) && (dueQ[0] == cycle + 1);
            checkValue("peakValid", expPeakValid, peakOut.valid);
            if (resultValid && !expValid) begin
                $display("ERROR %s: resultValid pulsed at cycle %0d with no result due",
                         testLabel(testId), cycle);
                pulseErrors++;
            end else if (!resultValid && expValid) begin
                $display("ERROR %s: resultValid missing at cycle %0d, 18 cycles after acqFinish",
                         testLabel(testId), cycle);
                pulseErrors++;
            end
            if (expValid) begin
                if (resultValid) begin
                    checkValue("peakCH", expPeakQ[0].peakCH, peakOut.peakCH);
                    checkValue("peakFH", expPeakQ[0].peakFH, peakOut.peakFH);
                    checkValue("thMinus", expThQ[0].thMinus, threshold.thMinus);
                    checkValue("thPositive", expThQ[0].thPositive, threshold.thPositive);
                    checkValue("delta", expThQ[0].delta, threshold.delta);
                end
                void'(dueQ.pop_front());
                void'(expPeakQ.pop_front());
                void'(expThQ.pop_front());
            end
            if (busyLeft == 0) begin
                // counting uses the enables from before this edge
                for (int h = 0; h < 2; h++) begin
                    if (wrEn[h] && modelCfg.histEnable[h] &&
                        modelHist[h][addr] < countCeil) begin
                        modelHist[h][addr]++;
                    end
                end
                if (cfgWrite) begin
                    modelCfg = cfgData;
                end
                if (acqFinish) begin
                    // larger count wins, lowest bin on a tie
                    for (int h = 0; h < 2; h++) begin
                        best   = modelHist[h][0];
                        bin[h] = 0;
                        for (int b = 1; b < sifhPkg::numBins; b++) begin
                            if (modelHist[h][b] > best) begin
                                best   = modelHist[h][b];
                                bin[h] = b;
                            end
                        end
                    end
                    // window around the CH peak, clamped to the bin range
                    pk    = bin[0];
                    hw    = modelCfg.halfWidth;
                    lower = (pk >= hw) ? pk - hw : 0;
                    upper = (pk + hw > sifhPkg::numBins - 1) ? sifhPkg::numBins - 1 : pk + hw;
                    dueQ.push_back(cycle + 19);
                    expPeakQ.push_back('{valid: 1'b1, peakCH: bin[0], peakFH: bin[1]});
                    expThQ.push_back('{thMinus: lower, thPositive: upper,
                                       delta: upper - lower});
                    // readout clears every bin
                    for (int h = 0; h < 2; h++) begin
                        for (int b = 0; b < sifhPkg::numBins; b++) begin
                            modelHist[h][b] = 0;
                        end
                    end
                    busyLeft = sifhPkg::numBins + 1;
                end
            end else begin
                busyLeft--;
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/sifhTb.sv
`timescale 1ns/1ps
`default_nettype none

module sifhTb;

    // sequence below needs roughly 3500 cycles in the worst case
    localparam int          timeoutCycles = 6000;
    localparam logic [31:0] lcgSeed       = 32'h77f7_836d;

    logic               clk;
    logic               arstN;
    sifhPkg::histSelT   wrEn;
    sifhPkg::binAddrT   addr;
    logic               acqFinish;
    logic               cfgWrite;
    sifhPkg::sifhCfgT   cfgData;
    logic               busy;
    sifhPkg::peakT      peakOut;
    sifhPkg::thresholdT threshold;
    logic               resultValid;

    logic [3:0]         testId;
    int                 mismatchCount;
    int                 pulseErrors;
    logic [31:0]        lcgState;
    int                 cycleCount;
    int                 hw;
    int                 pk;

    sifhClockGen clockGen (
        .clk   (clk),
        .arstN (arstN)
    );

    sifhTop uut (
        .clk         (clk),
        .arstN       (arstN),
        .wrEn        (wrEn),
        .addr        (addr),
        .acqFinish   (acqFinish),
        .cfgWrite    (cfgWrite),
        .cfgData     (cfgData),
        .busy        (busy),
        .peakOut     (peakOut),
        .threshold   (threshold),
        .resultValid (resultValid)
    );

    sifhChecker checkerU0 (
        .clk           (clk),
        .arstN         (arstN),
        .testId        (testId),
        .wrEn          (wrEn),
        .addr          (addr),
        .acqFinish     (acqFinish),
        .cfgWrite      (cfgWrite),
        .cfgData       (cfgData),
        .busy          (busy),
        .peakOut       (peakOut),
        .threshold     (threshold),
        .resultValid   (resultValid),
        .mismatchCount (mismatchCount),
        .pulseErrors   (pulseErrors)
    );

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // all tasks start and end on a falling edge
    task automatic driveWrite(input sifhPkg::histSelT mask, input sifhPkg::binAddrT bin);
        wrEn = mask;
        addr = bin;
        @(negedge clk);
        wrEn = '0;
    endtask

    task automatic randomWrites(input int n);
        logic [31:0] r;
        repeat (n) begin
            r = lcgNext();
            driveWrite(r[17:16], r[23:20]);
        end
    endtask

    task automatic writeCfg(input int halfWidth, input sifhPkg::histSelT enables);
        cfgData  = '{halfWidth: halfWidth, histEnable: enables};
        cfgWrite = 1'b1;
        @(negedge clk);
        cfgWrite = 1'b0;
    endtask

    task automatic acquire();
        logic [31:0] r;
        acqFinish = 1'b1;
        @(negedge clk);
        // random traffic while busy, all of it must be dropped
        repeat (sifhPkg::numBins) begin
            r         = lcgNext();
            wrEn      = r[17:16];
            addr      = r[23:20];
            acqFinish = r[24];
            cfgWrite  = r[25];
            cfgData   = r[31:26];
            @(negedge clk);
        end
        wrEn      = '0;
        acqFinish = 1'b0;
        cfgWrite  = 1'b0;
        while (!resultValid) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    // watchdog
    initial begin
        cycleCount = 0;
        while (cycleCount < timeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: run did not finish within %0d cycles", timeoutCycles);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        wrEn      = '0;
        addr      = '0;
        acqFinish = 1'b0;
        cfgWrite  = 1'b0;
        cfgData   = '0;
        testId    = 4'd0;
        lcgState  = lcgSeed;
        @(posedge arstN);
        @(negedge clk);

        testId = 4'd1;
        repeat (4) begin
            randomWrites(50 + int'(lcgNext() % 500));
            acquire();
        end

        // bin 6 saturates, bin 11 ties it at the ceiling
        // a wrapping counter would hand the peak to bin 11
        testId = 4'd2;
        repeat (300) driveWrite(2'b11, 4'd6);
        repeat (255) driveWrite(2'b11, 4'd11);
        acquire();

        // CH peak at bin 0, bin 15 and a random mid bin
        testId = 4'd3;
        for (int i = 0; i < 3; i++) begin
            hw = (i == 0) ? 0 : (i == 1) ? 3 : 15;
            for (int j = 0; j < 3; j++) begin
                pk = (j == 0) ? 0 : (j == 1) ? 15 : 1 + int'(lcgNext() % 14);
                writeCfg(hw, 2'b11);
                repeat (3) driveWrite(2'b01, pk);
                acquire();
            end
        end

        // FH disabled, its peak falls back to bin 0
        testId = 4'd4;
        writeCfg(2, 2'b01);
        randomWrites(80);
        acquire();
        writeCfg(2, 2'b11);

        // second readout starts from empty arrays
        testId = 4'd5;
        writeCfg(4, 2'b11);
        randomWrites(120);
        acquire();
        acquire();

        repeat (3) @(negedge clk);
        $display("closing: %0d mismatches, %0d resultValid errors",
                 mismatchCount, pulseErrors);
        if (mismatchCount == 0 && pulseErrors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
hdl/sifhPkg.sv
hdl/thresholdConfig.sv
hdl/hisBuilderReg.sv
hdl/peakDetecter.sv
hdl/algebraicBlock.sv
hdl/sifhTop.sv
verification/sifhClockGen.sv
verification/sifhChecker.sv
verification/sifhTb.sv

// File: Bender.yml
package:
  name: sifh

sources:
  - hdl/sifhPkg.sv
  - hdl/thresholdConfig.sv
  - hdl/hisBuilderReg.sv
  - hdl/peakDetecter.sv
  - hdl/algebraicBlock.sv
  - hdl/sifhTop.sv
  - target: simulation
    files:
      - verification/sifhClockGen.sv
      - verification/sifhChecker.sv
      - verification/sifhTb.sv
